//--- kbd_display.f
verilog/kbd_pkg.sv
verilog/ps2_receiver.sv
verilog/key_event_fsm.sv
verilog/scancode_rom.sv
verilog/seg_display.sv
verilog/kbd_display.sv
tests/kbd_display_chk.sv
tests/kbd_display_tb.sv

//--- tests/kbd_display_chk.sv
module kbd_display_chk import kbd_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       ready,
    input logic       next_n,
    input logic       blank,
    input logic [6:0] release_count
);

    timeunit 1ns;
    timeprecision 1ps;

    int assert_errors = 0;

    pop_needs_ready: assert property (@(posedge clk) disable iff (!rst) !next_n |-> ready)
    else
    begin
        $error("next_n low while the receiver queue is empty");
        assert_errors++;
    end

    pop_single_cycle: assert property (@(posedge clk) disable iff (!rst) !next_n |=> next_n)
    else
    begin
        $error("next_n held low for two cycles");
        assert_errors++;
    end

    count_in_range: assert property (@(posedge clk) disable iff (!rst)
        release_count <= COUNT_WRAP - 7'd1)
    else
    begin
        $error("release counter above 99");
        assert_errors++;
    end

    blank_after_reset: assert property (@(posedge clk) !rst |=> blank)
    else
    begin
        $error("display not blanked after reset");
        assert_errors++;
    end

endmodule

bind key_event_fsm kbd_display_chk chk0
(
    .clk           (clk),
    .rst           (rst),
    .ready         (ready),
    .next_n        (next_n),
    .blank         (blank),
    .release_count (release_count)
);

//--- tests/kbd_display_tb.sv
module kbd_display_tb import kbd_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_BIT   = 20;      // PS/2 clock half-period in system clocks.
    localparam int SETTLE     = 40;
    localparam int NUM_FRAMES = 308;     // 6 make, 2 release, 1 unmapped, 2 parity, 297 wrap.
    localparam int WATCHDOG   = NUM_FRAMES * 1000 + 2000;

    logic        clk     = 1'b0;
    logic        rst     = 1'b0;
    logic        ps2_clk = 1'b1;
    logic        ps2_dat = 1'b1;
    logic [7:0]  seg1;
    logic [7:0]  seg2;
    logic [7:0]  seg3;
    logic [7:0]  seg4;
    logic [7:0]  seg5;
    logic [7:0]  seg6;
    logic [7:0]  scan_tab [38];
    logic [7:0]  seg_tab [16];
    logic [31:0] lfsr_state = 32'h995d;
    int          errors = 0;
    int          checks = 0;
    logic [7:0]  cur_code;
    logic [7:0]  cur_ascii;
    logic        cur_blank;
    int          cur_count;

    kbd_display dut0
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg1    (seg1),
        .seg2    (seg2),
        .seg3    (seg3),
        .seg4    (seg4),
        .seg5    (seg5),
        .seg6    (seg6)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1.
    endfunction

    // Six fresh bits, folded onto the 38 table entries.
    function automatic int pick_key();
        int val;
        int i;
        val = 0;
        for (i = 0; i < 6; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
        return val % 38;
    endfunction

    function automatic logic [7:0] ascii_of(input int idx);
        if (idx < 26)
            return 8'(97 + idx);                 // Letters a to z.
        else if (idx < 36)
            return 8'(48 + idx - 26);            // Digits 0 to 9.
        else if (idx == 36)
            return 8'd32;
        else
            return 8'd13;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Start, eight data bits LSB first, odd parity, stop.
    task automatic send_frame(input logic [7:0] code, input bit bad_parity);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (i = 0; i < 11; i++)
        begin
            @(posedge clk);
            ps2_dat <= bits[i];
            wait_cycles(HALF_BIT);
            ps2_clk <= 1'b0;
            wait_cycles(HALF_BIT);
            ps2_clk <= 1'b1;
        end
        @(posedge clk);
        ps2_dat <= 1'b1;
    endtask

    task automatic compare_seg(input string name, input string digit,
                               input logic [7:0] expected, input logic [7:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERR %s %s expected %h actual %h", name, digit, expected, actual);
        end
    endtask

    task automatic check_display(input string name);
        @(negedge clk);
        compare_seg(name, "seg1", cur_blank ? SEG_BLANK : seg_tab[cur_code[3:0]], seg1);
        compare_seg(name, "seg2", cur_blank ? SEG_BLANK : seg_tab[cur_code[7:4]], seg2);
        compare_seg(name, "seg3", cur_blank ? SEG_BLANK : seg_tab[cur_ascii % 10], seg3);
        compare_seg(name, "seg4", cur_blank ? SEG_BLANK : seg_tab[cur_ascii / 10], seg4);
        compare_seg(name, "seg5", seg_tab[cur_count % 10], seg5);
        compare_seg(name, "seg6", seg_tab[cur_count / 10], seg6);
    endtask

    task automatic press_key(input logic [7:0] code, input logic [7:0] ascii,
                             input string name);
        send_frame(code, 1'b0);
        wait_cycles(SETTLE);
        cur_code  = code;
        cur_ascii = ascii;
        cur_blank = 1'b0;
        check_display(name);
    endtask

    // The prefix alone must leave the display as it was.
    task automatic release_key(input string name);
        send_frame(BREAK_CODE, 1'b0);
        wait_cycles(SETTLE);
        check_display(name);
        send_frame(cur_code, 1'b0);
        wait_cycles(SETTLE);
        cur_blank = 1'b1;
        cur_count = (cur_count + 1) % 100;
        check_display(name);
    endtask

    task automatic random_make_codes();
        int idx;
        repeat (6)
        begin
            idx = pick_key();
            press_key(scan_tab[idx], ascii_of(idx), "make_code");
        end
    endtask

    task automatic parity_error_drop();
        send_frame(scan_tab[0], 1'b1);
        wait_cycles(SETTLE);
        check_display("parity_error");
        press_key(scan_tab[0], ascii_of(0), "parity_error");
    endtask

    task automatic count_to_wrap();
        int idx;
        while (cur_count < 99)
        begin
            idx = pick_key();
            press_key(scan_tab[idx], ascii_of(idx), "count_wrap");
            release_key("count_wrap");
        end
        idx = pick_key();
        press_key(scan_tab[idx], ascii_of(idx), "count_wrap");
        release_key("count_wrap");
    endtask

    initial
    begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        scan_tab = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
                     8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
                     8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A,
                     8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E,
                     8'h46, 8'h29, 8'h5A};
        seg_tab  = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                     8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};
        cur_code  = 8'h00;
        cur_ascii = 8'h00;
        cur_blank = 1'b1;
        cur_count = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        wait_cycles(2);
        check_display("reset_state");
        random_make_codes();
        release_key("release");
        press_key(8'h76, 8'h00, "unmapped_code");
        parity_error_drop();
        count_to_wrap();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut0.dec0.chk0.assert_errors);
        if (errors == 0 && dut0.dec0.chk0.assert_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- verilog/kbd_display.sv
module kbd_display
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] seg1,
    output logic [7:0] seg2,
    output logic [7:0] seg3,
    output logic [7:0] seg4,
    output logic [7:0] seg5,
    output logic [7:0] seg6
);

    logic [7:0] rx_data;
    logic       rx_ready;
    logic       rx_overflow;
    logic       next_n;
    logic [7:0] key_code;
    logic [7:0] ascii;
    logic       blank;
    logic [6:0] release_count;

    ps2_receiver rx0
    (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .next_n   (next_n),
        .data     (rx_data),
        .ready    (rx_ready),
        .overflow (rx_overflow)
    );

    key_event_fsm dec0
    (
        .clk           (clk),
        .rst           (rst),
        .data          (rx_data),
        .ready         (rx_ready),
        .overflow      (rx_overflow),
        .next_n        (next_n),
        .key_code      (key_code),
        .blank         (blank),
        .release_count (release_count)
    );

    scancode_rom rom0
    (
        .clk   (clk),
        .code  (key_code),
        .ascii (ascii)
    );

    seg_display disp0
    (
        .clk           (clk),
        .rst           (rst),
        .key_code      (key_code),
        .ascii         (ascii),
        .blank         (blank),
        .release_count (release_count),
        .seg1          (seg1),
        .seg2          (seg2),
        .seg3          (seg3),
        .seg4          (seg4),
        .seg5          (seg5),
        .seg6          (seg6)
    );

endmodule

//--- verilog/kbd_pkg.sv
package kbd_pkg;

    // Decoder states. Make and break each end on a one-cycle pop.
    typedef enum logic [2:0]
    {
        st_idle,
        st_make,
        st_make_pop,
        st_break_pop,
        st_break_wait,
        st_break_done
    } kbd_state_t;

    // Scan-code set 2 prefix that precedes the code of a released key.
    localparam logic [7:0] BREAK_CODE = 8'hF0;

    // Receiver queue geometry.
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    // Release counter rolls over here, so it shows 00 to 99.
    localparam logic [6:0] COUNT_WRAP = 7'd100;

    // Active-low segments, all dark including the decimal point.
    localparam logic [7:0] SEG_BLANK = 8'hFF;

endpackage

//--- verilog/key_event_fsm.sv
module key_event_fsm import kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] data,
    input  logic       ready,
    input  logic       overflow,
    output logic       next_n,
    output logic [7:0] key_code,
    output logic       blank,
    output logic [6:0] release_count
);

    kbd_state_t state;
    logic       byte_avail;

    // A full flag without a head entry never starts a pop.
    assign byte_avail = ready & ~(overflow & ~ready);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state  <= st_idle;
            next_n <= 1'b1;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    next_n <= 1'b1;
                    if (byte_avail)
                        state <= (data == BREAK_CODE) ? st_break_pop : st_make;
                end
                st_make:
                begin
                    next_n <= 1'b0;          // Head is latched at this edge.
                    state  <= st_make_pop;
                end
                st_make_pop:
                begin
                    next_n <= 1'b1;
                    state  <= st_idle;
                end
                st_break_pop:
                begin
                    next_n <= 1'b0;          // Discard the F0 prefix.
                    state  <= st_break_wait;
                end
                st_break_wait:
                begin
                    // The prefix is still at the head during its own pop cycle.
                    if (byte_avail && next_n)
                    begin
                        next_n <= 1'b0;
                        state  <= st_break_done;
                    end
                    else
                        next_n <= 1'b1;
                end
                st_break_done:
                begin
                    next_n <= 1'b1;
                    state  <= st_idle;
                end
                default:
                begin
                    next_n <= 1'b1;
                    state  <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            key_code      <= 8'd0;
            blank         <= 1'b1;
            release_count <= 7'd0;
        end
        else if (state == st_make)
        begin
            key_code <= data;
            blank    <= 1'b0;
        end
        else if (state == st_break_done)
        begin
            blank <= 1'b1;                   // The key code itself is kept.
            if (release_count == COUNT_WRAP - 7'd1)
                release_count <= 7'd0;
            else
                release_count <= release_count + 7'd1;
        end
    end

endmodule

//--- verilog/ps2_receiver.sv
module ps2_receiver import kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    input  logic       next_n,
    output logic [7:0] data,
    output logic       ready,
    output logic       overflow
);

    logic             clk_s1;
    logic             clk_s2;
    logic             clk_s3;
    logic             dat_s1;
    logic             dat_s2;
    logic             clk_fall;
    logic [10:0]      frame;
    logic [3:0]       bit_cnt;
    logic             frame_done;
    logic             frame_ok;
    logic             push;
    logic [7:0]       push_byte;
    logic [7:0]       fifo_mem [FIFO_DEPTH];
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;
    logic [FIFO_AW:0] fill;
    logic             pop;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_s1 <= 1'b1;                  // Both PS/2 lines idle high.
            clk_s2 <= 1'b1;
            clk_s3 <= 1'b1;
            dat_s1 <= 1'b1;
            dat_s2 <= 1'b1;
        end
        else
        begin
            clk_s1 <= ps2_clk;
            clk_s2 <= clk_s1;
            clk_s3 <= clk_s2;                // Previous value for edge detect.
            dat_s1 <= ps2_dat;
            dat_s2 <= dat_s1;
        end
    end

    assign clk_fall = clk_s3 & ~clk_s2;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt    <= 4'd0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (clk_fall)
            begin
                if (bit_cnt == 4'd10)
                begin
                    bit_cnt    <= 4'd0;
                    frame_done <= 1'b1;      // Stop bit just shifted in.
                end
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // LSB first, so the newest bit enters at the top.
    always_ff @(posedge clk)
    begin
        if (clk_fall)
            frame <= {dat_s2, frame[10:1]};
    end

    // Start low, stop high, odd parity over data and parity bit.
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    always_ff @(posedge clk)
    begin
        if (!rst)
            push <= 1'b0;
        else
            push <= frame_done & frame_ok & ~overflow;  // Dropped when full.
    end

    always_ff @(posedge clk)
    begin
        if (frame_done)
            push_byte <= frame[8:1];
    end

    always_ff @(posedge clk)
    begin
        if (push)
            fifo_mem[wr_ptr[FIFO_AW-1:0]] <= push_byte;
    end

    assign pop = ~next_n & ready;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign fill     = wr_ptr - rd_ptr;   // Extra pointer bit tells full from empty.
    assign ready    = (fill != '0);
    assign overflow = (fill == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign data     = fifo_mem[rd_ptr[FIFO_AW-1:0]];

endmodule

//--- verilog/scancode_rom.sv
module scancode_rom
(
    input  logic       clk,
    input  logic [7:0] code,
    output logic [7:0] ascii
);

    // Set 2 make codes to lowercase ASCII.
    always_ff @(posedge clk)
    begin
        case (code)
            8'h1C: ascii <= 8'd97;
            8'h32: ascii <= 8'd98;
            8'h21: ascii <= 8'd99;
            8'h23: ascii <= 8'd100;
            8'h24: ascii <= 8'd101;
            8'h2B: ascii <= 8'd102;
            8'h34: ascii <= 8'd103;
            8'h33: ascii <= 8'd104;
            8'h43: ascii <= 8'd105;
            8'h3B: ascii <= 8'd106;
            8'h42: ascii <= 8'd107;
            8'h4B: ascii <= 8'd108;
            8'h3A: ascii <= 8'd109;
            8'h31: ascii <= 8'd110;
            8'h44: ascii <= 8'd111;
            8'h4D: ascii <= 8'd112;
            8'h15: ascii <= 8'd113;
            8'h2D: ascii <= 8'd114;
            8'h1B: ascii <= 8'd115;
            8'h2C: ascii <= 8'd116;
            8'h3C: ascii <= 8'd117;
            8'h2A: ascii <= 8'd118;
            8'h1D: ascii <= 8'd119;
            8'h22: ascii <= 8'd120;
            8'h35: ascii <= 8'd121;
            8'h1A: ascii <= 8'd122;
            8'h45: ascii <= 8'd48;   // Digits row, 0 to 9.
            8'h16: ascii <= 8'd49;
            8'h1E: ascii <= 8'd50;
            8'h26: ascii <= 8'd51;
            8'h25: ascii <= 8'd52;
            8'h2E: ascii <= 8'd53;
            8'h36: ascii <= 8'd54;
            8'h3D: ascii <= 8'd55;
            8'h3E: ascii <= 8'd56;
            8'h46: ascii <= 8'd57;
            8'h29: ascii <= 8'd32;   // Space.
            8'h5A: ascii <= 8'd13;   // Enter gives carriage return.
            default: ascii <= 8'd0;
        endcase
    end

endmodule

//--- verilog/seg_display.sv
module seg_display import kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] key_code,
    input  logic [7:0] ascii,
    input  logic       blank,
    input  logic [6:0] release_count,
    output logic [7:0] seg1,
    output logic [7:0] seg2,
    output logic [7:0] seg3,
    output logic [7:0] seg4,
    output logic [7:0] seg5,
    output logic [7:0] seg6
);

    logic [3:0] asc_ones;
    logic [3:0] asc_tens;
    logic [3:0] cnt_ones;
    logic [3:0] cnt_tens;

    // Bit 7 is the decimal point, bits 6 to 0 are g to a, all active low.
    function automatic logic [7:0] hex_to_seg(input logic [3:0] digit);
        case (digit)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    assign asc_ones = 4'(ascii % 8'd10);
    assign asc_tens = 4'(ascii / 8'd10);         // Up to 12 for lowercase letters.
    assign cnt_ones = 4'(release_count % 7'd10);
    assign cnt_tens = 4'(release_count / 7'd10);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            seg1 <= SEG_BLANK;
            seg2 <= SEG_BLANK;
            seg3 <= SEG_BLANK;
            seg4 <= SEG_BLANK;
            seg5 <= hex_to_seg(4'd0);
            seg6 <= hex_to_seg(4'd0);
        end
        else
        begin
            seg1 <= blank ? SEG_BLANK : hex_to_seg(key_code[3:0]);
            seg2 <= blank ? SEG_BLANK : hex_to_seg(key_code[7:4]);
            seg3 <= blank ? SEG_BLANK : hex_to_seg(asc_ones);
            seg4 <= blank ? SEG_BLANK : hex_to_seg(asc_tens);
            seg5 <= hex_to_seg(cnt_ones);    // Counter stays lit during blanking.
            seg6 <= hex_to_seg(cnt_tens);
        end
    end

endmodule
